/* run_sim.sh */
#!/bin/sh
# Build and run the setup unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cu_setup -f vlog.f -o sim_cu_setup
./obj_dir/sim_cu_setup | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "Done: no errors" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

/* tests/tb_cu_setup.sv */
// Setup unit testbench with clock, reset, descriptor runs, memory model and checks
`default_nettype none
`timescale 1ns/10ps

module tb_cu_setup;

    import cu_setup_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic        ap_clk = 1'b0;
    logic        areset_cu_setup = 1'b1;
    logic        descriptor_valid = 1'b0;
    logic        flush_request = 1'b0;
    logic        response_valid = 1'b0;
    logic        request_ready = 1'b0;
    addr_t       descriptor_base = '0;
    word_count_t descriptor_program_words = '0;
    word_count_t descriptor_flush_words = '0;
    logic        request_valid;
    addr_t       request_addr;
    logic        request_flush;
    logic        done;

    integer seed = 73682;
    int     timer;

    // Expected run and memory model state
    addr_t  base_exp;
    int     prog_words_exp;
    int     flush_words_exp;
    int     prog_accepts;
    int     flush_accepts;
    int     pending;
    int     resp_returned;
    logic   flush_sent = 1'b0;
    logic   accept;
    logic   give_resp;

    cu_setup DUT (.*);

    always #4 ap_clk = ~ap_clk;

    // ----------------------------------------
    // Downstream readiness and memory model
    // ----------------------------------------
    always @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            response_valid <= 1'b0;
            pending        <= 0;
            prog_accepts   <= 0;
            flush_accepts  <= 0;
            resp_returned  <= 0;
        end else begin
            accept    = request_valid && request_ready;
            // One response per accepted request, after a random delay
            give_resp = (pending != 0) && (($random(seed) & 1) != 0);
            // Ready about three cycles in eight so the queue backs up
            request_ready  <= (($random(seed) & 7) < 3);
            response_valid <= give_resp;
            pending        <= pending + int'(accept) - int'(give_resp);
            resp_returned  <= resp_returned + int'(give_resp);
            prog_accepts   <= prog_accepts + int'(accept && !flush_sent);
            flush_accepts  <= flush_accepts + int'(accept && flush_sent);
        end
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    // Word i of a phase sits at base plus 4*i
    a_request_order: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        request_valid && request_ready |->
            request_addr == base_exp + 4 * (flush_sent ? flush_accepts : prog_accepts))
        else report_error("request address out of sequence");

    a_request_count: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        request_valid && request_ready |->
            (flush_sent ? flush_accepts < flush_words_exp : prog_accepts < prog_words_exp))
        else report_error("more requests than the phase word count");

    // Tag 1 only after the flush command that the sequencer can take
    a_request_tag: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        request_valid |-> request_flush == flush_sent)
        else report_error("request flush tag does not match the phase");

    a_request_hold: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        request_valid && !request_ready |=>
            request_valid && $stable(request_addr) && $stable(request_flush))
        else report_error("stalled request changed before it was taken");

    // Done only once both phases are fully drained
    a_done_complete: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        done |-> flush_sent && !request_valid && prog_accepts == prog_words_exp &&
            flush_accepts == flush_words_exp &&
            resp_returned == prog_words_exp + flush_words_exp)
        else report_error("done raised before all requests and responses");

    a_done_sticky: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        done |=> done)
        else report_error("done fell before reset");

    task automatic report_error(input string msg);
        $display("Done: errors found");
        $display("[ERROR] %0t: %s", $time, msg);
        $fatal(1, "stopped at the first error");
    endtask

    // One clock of a wait loop bounded by TIMEOUT_CYCLES
    task automatic wait_cycle(input string what);
        @(posedge ap_clk);
        timer++;
        if (timer > TIMEOUT_CYCLES) begin
            $display("Done: errors found");
            $display("Timed out waiting for %s", what);
            $fatal(1, "stopped on timeout");
        end
    endtask

    // ----------------------------------------
    // Scenarios
    // ----------------------------------------
    task automatic run_scenario(input addr_t base, input int prog_words,
                                input int flush_words, input bit early_flush);
        @(posedge ap_clk);
        areset_cu_setup <= 1'b1;
        flush_sent      <= 1'b0;
        base_exp        <= base;
        prog_words_exp  <= prog_words;
        flush_words_exp <= flush_words;
        repeat (2) @(posedge ap_clk);
        areset_cu_setup          <= 1'b0;
        descriptor_valid         <= 1'b1;
        descriptor_base          <= base;
        descriptor_program_words <= word_count_t'(prog_words);
        descriptor_flush_words   <= word_count_t'(flush_words);
        @(posedge ap_clk);
        descriptor_valid <= 1'b0;
        timer = 0;
        while (early_flush && prog_accepts == 0) begin
            wait_cycle("the first program request");
        end
        // Program responses still out here so this flush must be ignored
        flush_request <= early_flush;
        @(posedge ap_clk);
        flush_request <= 1'b0;
        timer = 0;
        while (resp_returned < prog_words) begin
            wait_cycle("the program responses");
        end
        // Sequencer reaches PROG_DONE two clocks after the last response
        repeat (3) @(posedge ap_clk);
        flush_request <= 1'b1;
        flush_sent    <= 1'b1;
        @(posedge ap_clk);
        flush_request <= 1'b0;
        timer = 0;
        while (!done) begin
            wait_cycle("done");
        end
        // Bus stays quiet and done stays high for a while
        repeat (6) @(posedge ap_clk);
    endtask

    initial begin
        // Full run with an early flush and then a run with no flush words
        run_scenario(32'h0000_1000, 20, 9, 1'b1);
        run_scenario(32'h4000_0ff0, 6, 0, 1'b0);
        $display("Done: no errors");
        $finish;
    end

endmodule : tb_cu_setup

`default_nettype wire

/* verilog/cu_setup.sv */
// Compute unit setup top: sequencer, serial read engine and request queue
`default_nettype none
`timescale 1ns/10ps

module cu_setup (
    input  wire logic                      ap_clk,
    input  wire logic                      areset_cu_setup,
    input  wire logic                      descriptor_valid,
    input  wire cu_setup_pkg::addr_t       descriptor_base,
    input  wire cu_setup_pkg::word_count_t descriptor_program_words,
    input  wire cu_setup_pkg::word_count_t descriptor_flush_words,
    input  wire logic                      flush_request,
    input  wire logic                      response_valid,
    input  wire logic                      request_ready,
    output logic                           request_valid,
    output cu_setup_pkg::addr_t            request_addr,
    output logic                           request_flush,
    output logic                           done
);

    import cu_setup_pkg::*;

    // Sequencer to engine
    logic        engine_start;
    addr_t       engine_base;
    word_count_t engine_words;
    logic        engine_flush;
    logic        engine_idle;

    // Engine to queue
    logic           push;
    request_entry_t push_entry;
    logic           almost_full;

    setup_sequencer u_sequencer (
        .ap_clk                  (ap_clk),
        .areset_cu_setup         (areset_cu_setup),
        .descriptor_valid        (descriptor_valid),
        .descriptor_base         (descriptor_base),
        .descriptor_program_words(descriptor_program_words),
        .descriptor_flush_words  (descriptor_flush_words),
        .flush_request           (flush_request),
        .response_valid          (response_valid),
        .engine_idle             (engine_idle),
        .engine_start            (engine_start),
        .engine_base             (engine_base),
        .engine_words            (engine_words),
        .engine_flush            (engine_flush),
        .done                    (done)
    );

    serial_read_engine u_engine (
        .ap_clk         (ap_clk),
        .areset_cu_setup(areset_cu_setup),
        .engine_start   (engine_start),
        .engine_base    (engine_base),
        .engine_words   (engine_words),
        .engine_flush   (engine_flush),
        .almost_full    (almost_full),
        .engine_idle    (engine_idle),
        .push           (push),
        .push_entry     (push_entry)
    );

    request_fifo u_request_fifo (
        .ap_clk         (ap_clk),
        .areset_cu_setup(areset_cu_setup),
        .push           (push),
        .push_entry     (push_entry),
        .request_ready  (request_ready),
        .almost_full    (almost_full),
        .request_valid  (request_valid),
        .request_addr   (request_addr),
        .request_flush  (request_flush)
    );

endmodule : cu_setup

`default_nettype wire

/* verilog/cu_setup_pkg.sv */
// Setup unit types: address, word count, queue entry and sequencer states
`default_nettype none

`include "cu_setup_settings.svh"

package cu_setup_pkg;

    typedef logic [`CU_SETUP_ADDR_W-1:0] addr_t;
    typedef logic [`CU_SETUP_COUNT_W-1:0] word_count_t;

    // Top bit is the flush tag, the rest the byte address
    typedef logic [`CU_SETUP_ADDR_W:0] request_entry_t;

    typedef enum logic [2:0] {
        SETUP_IDLE,
        SETUP_PROG_START,
        SETUP_PROG_BUSY,
        SETUP_PROG_DONE,
        SETUP_FLUSH_START,
        SETUP_FLUSH_BUSY,
        SETUP_DONE
    } setup_state_t;

endpackage : cu_setup_pkg

`default_nettype wire

/* verilog/cu_setup_settings.svh */
// Setup unit widths, request queue depth and almost-full threshold
`ifndef CU_SETUP_SETTINGS_SVH
`define CU_SETUP_SETTINGS_SVH

// Byte address and word count widths
`define CU_SETUP_ADDR_W 32
`define CU_SETUP_COUNT_W 16

// Memory word width in bits, one request per word
`define CU_SETUP_DATA_W 32

// Request queue sizing
`define CU_SETUP_FIFO_DEPTH 16
// Leaves room for an entry already in flight
`define CU_SETUP_PROG_THRESH 12

`endif

/* verilog/request_fifo.sv */
// Request queue: first-word-fall-through circular buffer with almost-full flag
`default_nettype none
`timescale 1ns/10ps

`include "cu_setup_settings.svh"

module request_fifo #(
    parameter int DEPTH  = `CU_SETUP_FIFO_DEPTH,
    parameter int THRESH = `CU_SETUP_PROG_THRESH
) (
    input  wire logic                         ap_clk,
    input  wire logic                         areset_cu_setup,
    input  wire logic                         push,
    input  wire cu_setup_pkg::request_entry_t push_entry,
    input  wire logic                         request_ready,
    output logic                              almost_full,
    output logic                              request_valid,
    output cu_setup_pkg::addr_t               request_addr,
    output logic                              request_flush
);

    import cu_setup_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    request_entry_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;
    request_entry_t   head;

    assign pop = request_valid && request_ready;

    // ----------------------------------------
    // Storage and pointers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Head entry shown while anything is stored
    assign head          = mem[rd_ptr];
    assign request_valid = (count != '0);
    assign request_addr  = head[`CU_SETUP_ADDR_W-1:0];
    assign request_flush = head[`CU_SETUP_ADDR_W];

    assign almost_full = (count >= CNT_W'(THRESH));

    // Engine must back off at the threshold before the buffer fills
    a_no_push_when_full: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        push |-> count != CNT_W'(DEPTH));

endmodule : request_fifo

`default_nettype wire

/* verilog/serial_read_engine.sv */
// Serial read engine: one word read request per cycle, stalled on almost full
`default_nettype none
`timescale 1ns/10ps

`include "cu_setup_settings.svh"

module serial_read_engine (
    input  wire logic                      ap_clk,
    input  wire logic                      areset_cu_setup,
    input  wire logic                      engine_start,
    input  wire cu_setup_pkg::addr_t       engine_base,
    input  wire cu_setup_pkg::word_count_t engine_words,
    input  wire logic                      engine_flush,
    input  wire logic                      almost_full,
    output logic                           engine_idle,
    output logic                           push,
    output cu_setup_pkg::request_entry_t   push_entry
);

    import cu_setup_pkg::*;

    // Byte step between consecutive words
    localparam addr_t ADDR_STEP = addr_t'(`CU_SETUP_DATA_W / 8);

    logic        busy;
    addr_t       addr_reg;
    word_count_t remaining;
    logic        flush_tag;

    // ----------------------------------------
    // Address and word counters
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (engine_start) begin
            addr_reg  <= engine_base;
            remaining <= engine_words;
            flush_tag <= engine_flush;
        end else if (push) begin
            addr_reg  <= addr_reg + ADDR_STEP;
            remaining <= remaining - 1'b1;
        end
    end

    // Zero-word phase never leaves idle
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            busy <= 1'b0;
        end else if (engine_start) begin
            busy <= (engine_words != '0);
        end else if (push && remaining == word_count_t'(1)) begin
            busy <= 1'b0;
        end
    end

    // Issue when busy and the queue has room
    assign push        = busy && !almost_full;
    assign push_entry  = {flush_tag, addr_reg};
    assign engine_idle = !busy;

    // Sequencer only starts a phase on a drained engine
    a_start_when_idle: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        engine_start |-> engine_idle);

endmodule : serial_read_engine

`default_nettype wire

/* verilog/setup_sequencer.sv */
// Setup sequencer: descriptor capture, phase FSM, response counter and done
`default_nettype none
`timescale 1ns/10ps

module setup_sequencer (
    input  wire logic                      ap_clk,
    input  wire logic                      areset_cu_setup,
    input  wire logic                      descriptor_valid,
    input  wire cu_setup_pkg::addr_t       descriptor_base,
    input  wire cu_setup_pkg::word_count_t descriptor_program_words,
    input  wire cu_setup_pkg::word_count_t descriptor_flush_words,
    input  wire logic                      flush_request,
    input  wire logic                      response_valid,
    input  wire logic                      engine_idle,
    output logic                           engine_start,
    output cu_setup_pkg::addr_t            engine_base,
    output cu_setup_pkg::word_count_t      engine_words,
    output logic                           engine_flush,
    output logic                           done
);

    import cu_setup_pkg::*;

    setup_state_t state;
    setup_state_t next_state;

    addr_t       base_reg;
    word_count_t program_words_reg;
    word_count_t flush_words_reg;
    logic        flush_phase;
    word_count_t resp_count;
    logic        phase_complete;

    // ----------------------------------------
    // Descriptor capture
    // ----------------------------------------
    // Held for the whole run, only taken in IDLE
    always_ff @(posedge ap_clk) begin
        if (state == SETUP_IDLE && descriptor_valid) begin
            base_reg          <= descriptor_base;
            program_words_reg <= descriptor_program_words;
            flush_words_reg   <= descriptor_flush_words;
        end
    end

    // Flush tag stays set from the flush command onwards
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            flush_phase <= 1'b0;
        end else if (state == SETUP_PROG_DONE && flush_request) begin
            flush_phase <= 1'b1;
        end
    end

    // ----------------------------------------
    // Phase state machine
    // ----------------------------------------
    // Engine drained and every response back
    assign phase_complete = engine_idle && (resp_count == '0);

    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            state <= SETUP_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            SETUP_IDLE: begin
                if (descriptor_valid) begin
                    next_state = SETUP_PROG_START;
                end
            end
            SETUP_PROG_START:  next_state = SETUP_PROG_BUSY;
            SETUP_PROG_BUSY: begin
                if (phase_complete) begin
                    next_state = SETUP_PROG_DONE;
                end
            end
            SETUP_PROG_DONE: begin
                if (flush_request) begin
                    next_state = SETUP_FLUSH_START;
                end
            end
            SETUP_FLUSH_START: next_state = SETUP_FLUSH_BUSY;
            SETUP_FLUSH_BUSY: begin
                if (phase_complete) begin
                    next_state = SETUP_DONE;
                end
            end
            SETUP_DONE:        next_state = SETUP_DONE;
            default:           next_state = SETUP_IDLE;
        endcase
    end

    // ----------------------------------------
    // Response counter
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_cu_setup) begin
            resp_count <= '0;
        end else if (engine_start) begin
            resp_count <= engine_words;
        end else if (response_valid &&
                     (state == SETUP_PROG_BUSY || state == SETUP_FLUSH_BUSY)) begin
            resp_count <= resp_count - 1'b1;
        end
    end

    // Engine command, start is a single cycle in either START state
    assign engine_start = (state == SETUP_PROG_START) || (state == SETUP_FLUSH_START);
    assign engine_base  = base_reg;
    assign engine_words = flush_phase ? flush_words_reg : program_words_reg;
    assign engine_flush = flush_phase;

    assign done = (state == SETUP_DONE);

    // More responses than requests issued in this phase
    a_no_extra_response: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        response_valid |-> resp_count != '0);

    a_done_sticky: assert property (@(posedge ap_clk) disable iff (areset_cu_setup)
        done |=> done);

endmodule : setup_sequencer

`default_nettype wire

/* vlog.f */
+incdir+verilog
verilog/cu_setup_pkg.sv
verilog/setup_sequencer.sv
verilog/serial_read_engine.sv
verilog/request_fifo.sv
verilog/cu_setup.sv
tests/tb_cu_setup.sv
